// File: verilog.f
router_pkg.sv
deq_notify_if.sv
queue_store.sv
port_scheduler.sv
dequeue_pipeline.sv
egress_buffer.sv
router_egress_top.sv
tb_router_model.sv
tb_router_egress.sv

// File: Makefile
# Verilator build and run of the router egress testbench
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tb_router_egress
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR FILELIST TOP BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb_router_egress.sv
// Directed priority and round-robin phases, then random traffic with random tx_ready
// Reads dut0.egr_buf_ready to see when a port's buffer is full
`default_nettype none

module tb_router_egress
    import router_pkg::*, tb_router_model::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                            dequeue_req;
    logic                            rst_n;
    logic                            enq_valid;
    logic [QID_W-1:0]                enq_qid;
    logic [DATA_W-1:0]               enq_data;
    logic                            enq_last;
    logic                            enq_ready;
    logic [NUM_EGR_PORTS-1:0]        tx_valid;
    logic [NUM_EGR_PORTS*DATA_W-1:0] tx_data;
    logic [NUM_EGR_PORTS-1:0]        tx_last;
    logic [NUM_EGR_PORTS-1:0]        tx_ready;

    logic                     rand_ready;
    logic [NUM_EGR_PORTS-1:0] ready_hold;

    router_egress_top dut0 (
        .dequeue_req (dequeue_req),
        .rst_n       (rst_n),
        .enq_valid   (enq_valid),
        .enq_qid     (enq_qid),
        .enq_data    (enq_data),
        .enq_last    (enq_last),
        .enq_ready   (enq_ready),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_last     (tx_last),
        .tx_ready    (tx_ready)
    );

    initial begin
        dequeue_req = 1'b0;
        forever #4 dequeue_req = ~dequeue_req;
    end

    // tx_ready is either held or random, changed on the falling edge
    initial begin
        tx_ready = '1;
        forever begin
            @(negedge dequeue_req);
            tx_ready <= rand_ready ? NUM_EGR_PORTS'($urandom) : ready_hold;
        end
    end

    task automatic abort_run(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    //////////////////////////////
    // Monitor

    always @(posedge dequeue_req) begin : tx_monitor
        bit    ok;
        word_t w;
        if (rst_n) begin
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                if (tx_valid[p] && tx_ready[p]) begin
                    w.data = tx_data[p*DATA_W +: DATA_W];
                    w.last = tx_last[p];
                    accept_tx_word(port_t'(p), w, ok);
                    if (!ok) begin
                        abort_run("");
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus tasks

    // Each word waits for enq_ready with enq_valid low, then strobes once
    task automatic send_packet(input qid_t q, input int len);
        word_t w;
        int    waited;
        for (int i = 0; i < len; i++) begin
            w.data = $urandom;
            w.last = (i == len - 1);
            @(negedge dequeue_req);
            enq_valid = 1'b0;
            enq_qid   = q;
            enq_data  = w.data;
            enq_last  = w.last;
            waited    = 0;
            do begin
                @(posedge dequeue_req);
                waited++;
                if (waited > ENQ_TIMEOUT) begin
                    abort_run($sformatf("enq_ready stayed low for queue %0d", q));
                end
            end while (!enq_ready);
            @(negedge dequeue_req);
            enq_valid = 1'b1;
            @(posedge dequeue_req);
            add_word(q, w);
        end
        @(negedge dequeue_req);
        enq_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_words() != 0 || tx_valid != '0) begin
            @(negedge dequeue_req);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("Queues and egress buffers did not drain in time");
            end
        end
    endtask

    //////////////////////////////
    // Main sequence

    initial begin : main_seq
        bit   ok;
        int   waited;
        qid_t q;
        void'($urandom(32'h932f_444d));
        rst_n      = 1'b0;
        enq_valid  = 1'b0;
        enq_qid    = '0;
        enq_data   = '0;
        enq_last   = 1'b0;
        rand_ready = 1'b0;
        ready_hold = '1;
        clear_model();
        repeat (RESET_CYCLES) @(negedge dequeue_req);
        rst_n = 1'b1;

        // Idle after reset
        repeat (8) begin
            @(posedge dequeue_req);
            check_flag("tx_valid any", |tx_valid, 1'b0, ok);
            if (!ok) abort_run("");
            check_flag("enq_ready", enq_ready, 1'b1, ok);
            if (!ok) abort_run("");
        end

        // Strict priority on port 1 behind a filler packet
        @(posedge dequeue_req);
        ready_hold = ~(NUM_EGR_PORTS'(1) << 1);
        q.port = port_t'(1);
        q.prio = prio_t'(0);
        send_packet(q, 12);
        waited = 0;
        while (!(tx_valid[1] && !dut0.egr_buf_ready[1])) begin
            @(negedge dequeue_req);
            waited++;
            if (waited > FILL_TIMEOUT) abort_run("Port 1 egress buffer never filled");
        end
        q.prio = prio_t'(1);
        send_packet(q, 3);
        q.prio = prio_t'(3);
        send_packet(q, 3);
        @(posedge dequeue_req);
        ready_hold = '1;
        wait_drain();
        check_flag("port 1 packet count", start_log[1].size() == 3, 1'b1, ok);
        if (!ok) abort_run("");
        check_flag("filler first", start_log[1][0].prio == prio_t'(0), 1'b1, ok);
        if (!ok) abort_run("");
        check_flag("prio 3 before prio 1", start_log[1][1].prio == prio_t'(3)
                   && start_log[1][2].prio == prio_t'(1), 1'b1, ok);
        if (!ok) abort_run("");

        // Every port loaded, each must finish a packet
        clear_model();
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            repeat (2) begin
                q.port = port_t'(p);
                q.prio = prio_t'($urandom_range(NUM_QUEUES_PER_EGR_PORT - 1));
                send_packet(q, $urandom_range(6, 1));
            end
        end
        waited = 0;
        while (!all_ports_done()) begin
            @(negedge dequeue_req);
            waited++;
            if (waited > RR_TIMEOUT) abort_run("A port sent no complete packet in time");
        end
        wait_drain();

        // Random traffic with random tx_ready
        @(posedge dequeue_req);
        rand_ready = 1'b1;
        repeat (RANDOM_PACKETS) begin
            q = qid_t'($urandom_range(NUM_QUEUES - 1));
            send_packet(q, $urandom_range(6, 1));
        end
        @(posedge dequeue_req);
        rand_ready = 1'b0;
        ready_hold = '1;
        wait_drain();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_router_model.sv
// Reference model of per-queue packet order for the egress testbench
// A new packet on a port is matched to a queue by its head word
`default_nettype none

package tb_router_model;
    import router_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int ENQ_TIMEOUT    = 2000;
    localparam int FILL_TIMEOUT   = 500;
    localparam int RR_TIMEOUT     = 1500;
    localparam int DRAIN_TIMEOUT  = 5000;
    localparam int RANDOM_PACKETS = 60;

    // Words enqueued but not yet seen on tx, one list per queue
    word_t exp_q     [NUM_QUEUES][$];
    logic  act_valid [NUM_EGR_PORTS];
    prio_t act_prio  [NUM_EGR_PORTS];
    int    pkt_done  [NUM_EGR_PORTS];
    qid_t  start_log [NUM_EGR_PORTS][$];

    function automatic void clear_model();
        for (int q = 0; q < NUM_QUEUES; q++) begin
            exp_q[q].delete();
        end
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            act_valid[p] = 1'b0;
            act_prio[p]  = '0;
            pkt_done[p]  = 0;
            start_log[p].delete();
        end
    endfunction

    function automatic void add_word(qid_t q, word_t w);
        exp_q[int'(q)].push_back(w);
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            n += exp_q[q].size();
        end
        return n;
    endfunction

    function automatic bit all_ports_done();
        bit done;
        done = 1'b1;
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            if (pkt_done[p] == 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    //////////////////////////////
    // Compare tasks

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input port_t got, input port_t exp,
                              output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // One word left port p, checked against its queue in FIFO order
    task automatic accept_tx_word(input port_t p, input word_t w, output bit ok);
        int   qi;
        bit   found;
        qid_t q;
        ok    = 1'b1;
        found = 1'b0;
        if (!act_valid[p]) begin
            for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
                if (!found && exp_q[i].size() != 0 && exp_q[i][0] == w) begin
                    found = 1'b1;
                    q     = qid_t'(i);
                end
            end
            if (!found) begin
                $display("Word 0x%h on port %0d matches no queued packet", w, p);
                ok = 1'b0;
                return;
            end
            check_port("tx port of queue", p, q.port, ok);
            if (!ok) begin
                return;
            end
            act_valid[p] = 1'b1;
            act_prio[p]  = q.prio;
            start_log[p].push_back(q);
        end
        q.port = p;
        q.prio = act_prio[p];
        qi     = int'(q);
        if (exp_q[qi].size() == 0) begin
            $display("Port %0d sent a word after its packet ran out of words", p);
            ok = 1'b0;
            return;
        end
        check_word($sformatf("tx word on port %0d", p), w, exp_q[qi][0], ok);
        if (!ok) begin
            return;
        end
        void'(exp_q[qi].pop_front());
        if (w.last) begin
            act_valid[p] = 1'b0;
            pkt_done[p]++;
        end
    endtask

endpackage

`default_nettype wire

// File: router_egress_top.sv
// tx_data and tx_last are valid only where the port's tx_valid bit is high
// enq_qid carries the port in its upper bits and the priority in its lower bits
`default_nettype none

module router_egress_top
    import router_pkg::*;
(
    input  logic                            dequeue_req,
    input  logic                            rst_n,
    input  logic                            enq_valid,
    input  logic [QID_W-1:0]                enq_qid,
    input  logic [DATA_W-1:0]               enq_data,
    input  logic                            enq_last,
    output logic                            enq_ready,
    output logic [NUM_EGR_PORTS-1:0]        tx_valid,
    output logic [NUM_EGR_PORTS*DATA_W-1:0] tx_data,
    output logic [NUM_EGR_PORTS-1:0]        tx_last,
    input  logic [NUM_EGR_PORTS-1:0]        tx_ready
);

    word_t                    enq_word;
    logic                     deq_cmd_valid;
    qid_t                     deq_cmd_qid;
    word_t                    deq_word;
    logic [NUM_QUEUES-1:0]    queue_empty;
    logic [NUM_EGR_PORTS-1:0] egr_buf_ready;
    word_t                    tx_word [NUM_EGR_PORTS];

    deq_notify_if notify_bus ();

    assign enq_word = '{data: enq_data, last: enq_last};

    always_comb begin
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            tx_data[p*DATA_W +: DATA_W] = tx_word[p].data;
            tx_last[p]                  = tx_word[p].last;
        end
    end

    queue_store u_queue_store (
        .dequeue_req   (dequeue_req),
        .rst_n         (rst_n),
        .enq_valid     (enq_valid),
        .enq_qid       (qid_t'(enq_qid)),
        .enq_word      (enq_word),
        .enq_ready     (enq_ready),
        .deq_cmd_valid (deq_cmd_valid),
        .deq_cmd_qid   (deq_cmd_qid),
        .deq_word      (deq_word),
        .queue_empty   (queue_empty)
    );

    port_scheduler u_port_scheduler (
        .dequeue_req   (dequeue_req),
        .rst_n         (rst_n),
        .queue_empty   (queue_empty),
        .egr_buf_ready (egr_buf_ready),
        .notify        (notify_bus),
        .deq_cmd_valid (deq_cmd_valid),
        .deq_cmd_qid   (deq_cmd_qid)
    );

    dequeue_pipeline u_dequeue_pipeline (
        .dequeue_req   (dequeue_req),
        .rst_n         (rst_n),
        .deq_cmd_valid (deq_cmd_valid),
        .deq_cmd_qid   (deq_cmd_qid),
        .deq_word      (deq_word),
        .notify        (notify_bus)
    );

    egress_buffer u_egress_buffer (
        .dequeue_req   (dequeue_req),
        .rst_n         (rst_n),
        .notify        (notify_bus),
        .egr_buf_ready (egr_buf_ready),
        .tx_valid      (tx_valid),
        .tx_word       (tx_word),
        .tx_ready      (tx_ready)
    );

endmodule

`default_nettype wire

// File: egress_buffer.sv
// Each port holds EGR_DEPTH words, head word included
// Notifications are always written, the ready margin keeps room for them
`default_nettype none

module egress_buffer
    import router_pkg::*;
(
    input  logic                     dequeue_req,
    input  logic                     rst_n,
    deq_notify_if.mon                notify,
    output logic [NUM_EGR_PORTS-1:0] egr_buf_ready,
    output logic [NUM_EGR_PORTS-1:0] tx_valid,
    output word_t                    tx_word [NUM_EGR_PORTS],
    input  logic [NUM_EGR_PORTS-1:0] tx_ready
);

    word_t buf_mem [NUM_EGR_PORTS][EGR_DEPTH];

    logic [EPTR_W-1:0] wr_ptr  [NUM_EGR_PORTS];
    logic [EPTR_W-1:0] rd_ptr  [NUM_EGR_PORTS];
    logic [ECNT_W-1:0] mem_cnt [NUM_EGR_PORTS];
    logic [ECNT_W-1:0] occ     [NUM_EGR_PORTS];

    logic [NUM_EGR_PORTS-1:0] push, load, bypass, mem_rd, mem_wr;

    //////////////////////////////
    // Control decode

    always_comb begin
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            push[p]   = notify.valid && (notify.qid.port == port_t'(p));
            // Head slot is free or leaves this cycle
            load[p]   = !tx_valid[p] || tx_ready[p];
            mem_rd[p] = load[p] && (mem_cnt[p] != '0);
            bypass[p] = load[p] && (mem_cnt[p] == '0) && push[p];
            mem_wr[p] = push[p] && !bypass[p];
            occ[p]    = mem_cnt[p] + ECNT_W'(tx_valid[p]);
            egr_buf_ready[p] = (occ[p] <= ECNT_W'(EGR_DEPTH - EGR_READY_FREE));
        end
    end

    always_ff @(posedge dequeue_req) begin
        if (!rst_n) begin
            tx_valid <= '0;
            wr_ptr   <= '{default: '0};
            rd_ptr   <= '{default: '0};
            mem_cnt  <= '{default: '0};
        end else begin
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                if (load[p]) begin
                    tx_valid[p] <= mem_rd[p] || bypass[p];
                end
                if (mem_wr[p]) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (mem_rd[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                if (mem_wr[p] && !mem_rd[p]) begin
                    mem_cnt[p] <= mem_cnt[p] + 1'b1;
                end else if (mem_rd[p] && !mem_wr[p]) begin
                    mem_cnt[p] <= mem_cnt[p] - 1'b1;
                end
            end
        end
    end

    // Words and registered head
    always_ff @(posedge dequeue_req) begin
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            if (mem_wr[p]) begin
                buf_mem[p][wr_ptr[p]] <= notify.word;
            end
            if (mem_rd[p]) begin
                tx_word[p] <= buf_mem[p][rd_ptr[p]];
            end else if (bypass[p]) begin
                tx_word[p] <= notify.word;
            end
        end
    end

    // Holds only if the scheduler honours egr_buf_ready
    a_no_overflow: assert property (
        @(posedge dequeue_req) disable iff (!rst_n)
        notify.valid |-> (occ[notify.qid.port] < ECNT_W'(EGR_DEPTH))
    );

endmodule

`default_nettype wire

// File: dequeue_pipeline.sv
// Fixed delay of DQ_LATENCY cycles, stands in for the packet memory read
// Requests may follow each other back to back
`default_nettype none

module dequeue_pipeline
    import router_pkg::*;
(
    input  logic      dequeue_req,
    input  logic      rst_n,
    input  logic      deq_cmd_valid,
    input  qid_t      deq_cmd_qid,
    input  word_t     deq_word,
    deq_notify_if.src notify
);

    //////////////////////////////
    // Stages

    logic [DQ_LATENCY-1:0] vld_sr;
    qid_t                  qid_sr  [DQ_LATENCY];
    word_t                 word_sr [DQ_LATENCY];

    // Stage 0 captures the word at the request edge
    always_ff @(posedge dequeue_req) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= deq_cmd_valid;
            for (int s = 1; s < DQ_LATENCY; s++) begin
                vld_sr[s] <= vld_sr[s-1];
            end
        end
    end

    always_ff @(posedge dequeue_req) begin
        qid_sr[0]  <= deq_cmd_qid;
        word_sr[0] <= deq_word;
        for (int s = 1; s < DQ_LATENCY; s++) begin
            qid_sr[s]  <= qid_sr[s-1];
            word_sr[s] <= word_sr[s-1];
        end
    end

    //////////////////////////////
    // Notification

    assign notify.valid = vld_sr[DQ_LATENCY-1];
    assign notify.qid   = qid_sr[DQ_LATENCY-1];
    assign notify.word  = word_sr[DQ_LATENCY-1];

endmodule

`default_nettype wire

// File: port_scheduler.sv
// One request per port per DQ_LATENCY+1 cycles, so one word in flight per port
// A locked port stalls until its active queue has words again
`default_nettype none

module port_scheduler
    import router_pkg::*;
(
    input  logic                     dequeue_req,
    input  logic                     rst_n,
    input  logic [NUM_QUEUES-1:0]    queue_empty,
    input  logic [NUM_EGR_PORTS-1:0] egr_buf_ready,
    deq_notify_if.mon                notify,
    output logic                     deq_cmd_valid,
    output qid_t                     deq_cmd_qid
);

    //////////////////////////////
    // State

    port_t egr_port_sel;
    logic  sel_valid;

    logic [NUM_EGR_PORTS-1:0] pkt_lock;
    prio_t                    active_prio [NUM_EGR_PORTS];

    // Bit 0 set on grant, port blocked while any bit is set
    logic [DQ_LATENCY:0] busy_sr [NUM_EGR_PORTS];

    logic [NUM_EGR_PORTS-1:0] port_elig;
    logic                     grant_found;
    port_t                    grant_port;
    logic                     pick_found;
    prio_t                    pick_prio;
    qid_t                     pick_qid;

    //////////////////////////////
    // Port stage

    always_comb begin
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            port_elig[p] = !(&queue_empty[p*NUM_QUEUES_PER_EGR_PORT +: NUM_QUEUES_PER_EGR_PORT])
                           && !(|busy_sr[p]) && egr_buf_ready[p];
        end
    end

    // Scan begins at the last granted port
    always_comb begin : port_scan
        port_t cand;
        grant_found = 1'b0;
        grant_port  = egr_port_sel;
        for (int i = 0; i < NUM_EGR_PORTS; i++) begin
            cand = port_t'((int'(egr_port_sel) + i) % NUM_EGR_PORTS);
            if (!grant_found && port_elig[cand]) begin
                grant_found = 1'b1;
                grant_port  = cand;
            end
        end
    end

    //////////////////////////////
    // Queue stage

    // Highest index wins unless a packet is already open on the port
    always_comb begin
        pick_prio  = active_prio[egr_port_sel];
        pick_found = 1'b0;
        if (pkt_lock[egr_port_sel]) begin
            pick_found = !queue_empty[{egr_port_sel, pick_prio}];
        end else begin
            for (int pr = NUM_QUEUES_PER_EGR_PORT - 1; pr >= 0; pr--) begin
                if (!pick_found && !queue_empty[{egr_port_sel, prio_t'(pr)}]) begin
                    pick_found = 1'b1;
                    pick_prio  = prio_t'(pr);
                end
            end
        end
    end

    assign pick_qid = '{port: egr_port_sel, prio: pick_prio};

    always_ff @(posedge dequeue_req) begin
        if (!rst_n) begin
            egr_port_sel  <= '0;
            sel_valid     <= 1'b0;
            busy_sr       <= '{default: '0};
            pkt_lock      <= '0;
            active_prio   <= '{default: '0};
            deq_cmd_valid <= 1'b0;
            deq_cmd_qid   <= '0;
        end else begin
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                busy_sr[p] <= {busy_sr[p][DQ_LATENCY-1:0],
                               grant_found && (grant_port == port_t'(p))};
            end
            sel_valid <= grant_found;
            if (grant_found) begin
                egr_port_sel <= grant_port;
            end

            deq_cmd_valid <= sel_valid && pick_found;
            deq_cmd_qid   <= pick_qid;

            // Last word seen on the notification closes the packet
            if (notify.valid && notify.word.last) begin
                pkt_lock[notify.qid.port] <= 1'b0;
            end
            if (sel_valid && pick_found && !pkt_lock[egr_port_sel]) begin
                pkt_lock[egr_port_sel]    <= 1'b1;
                active_prio[egr_port_sel] <= pick_prio;
            end
        end
    end

    //////////////////////////////
    // Checks

    // Only the grant one cycle back sits in the busy window of the request port
    a_req_in_window: assert property (
        @(posedge dequeue_req) disable iff (!rst_n)
        deq_cmd_valid |-> (busy_sr[deq_cmd_qid.port][1] && $onehot(busy_sr[deq_cmd_qid.port]))
    );

    a_req_not_empty: assert property (
        @(posedge dequeue_req) disable iff (!rst_n)
        deq_cmd_valid |-> !queue_empty[deq_cmd_qid]
    );

endmodule

`default_nettype wire

// File: queue_store.sv
// enq_ready follows the queue addressed by enq_qid in the same cycle
// Pops are not checked here, the scheduler only requests non-empty queues
`default_nettype none

module queue_store
    import router_pkg::*;
(
    input  logic                  dequeue_req,
    input  logic                  rst_n,
    input  logic                  enq_valid,
    input  qid_t                  enq_qid,
    input  word_t                 enq_word,
    output logic                  enq_ready,
    input  logic                  deq_cmd_valid,
    input  qid_t                  deq_cmd_qid,
    output word_t                 deq_word,
    output logic [NUM_QUEUES-1:0] queue_empty
);

    //////////////////////////////
    // Storage and pointers

    // All queues share one memory, queue number in the upper address bits
    word_t mem [NUM_QUEUES*QUEUE_DEPTH];

    logic [QPTR_W-1:0] wr_ptr [NUM_QUEUES];
    logic [QPTR_W-1:0] rd_ptr [NUM_QUEUES];
    logic [QCNT_W-1:0] count  [NUM_QUEUES];

    logic                  enq_fire;
    logic [NUM_QUEUES-1:0] q_inc;
    logic [NUM_QUEUES-1:0] q_dec;

    //////////////////////////////
    // Status

    assign enq_ready = (count[enq_qid] != QCNT_W'(QUEUE_DEPTH));
    assign enq_fire  = enq_valid && enq_ready;

    // One-hot per queue
    assign q_inc = enq_fire ? (NUM_QUEUES'(1) << enq_qid) : '0;
    assign q_dec = deq_cmd_valid ? (NUM_QUEUES'(1) << deq_cmd_qid) : '0;

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            queue_empty[q] = (count[q] == '0);
        end
    end

    // Head of requested queue, read in the request cycle
    assign deq_word = mem[{deq_cmd_qid, rd_ptr[deq_cmd_qid]}];

    //////////////////////////////
    // Update

    always_ff @(posedge dequeue_req) begin
        if (enq_fire) begin
            mem[{enq_qid, wr_ptr[enq_qid]}] <= enq_word;
        end
    end

    always_ff @(posedge dequeue_req) begin
        if (!rst_n) begin
            wr_ptr <= '{default: '0};
            rd_ptr <= '{default: '0};
            count  <= '{default: '0};
        end else begin
            if (enq_fire) begin
                wr_ptr[enq_qid] <= wr_ptr[enq_qid] + 1'b1;
            end
            if (deq_cmd_valid) begin
                rd_ptr[deq_cmd_qid] <= rd_ptr[deq_cmd_qid] + 1'b1;
            end
            // Enqueue and pop on the same queue leave the count as it is
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (q_inc[q] && !q_dec[q]) begin
                    count[q] <= count[q] + 1'b1;
                end else if (q_dec[q] && !q_inc[q]) begin
                    count[q] <= count[q] - 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Checks

    // Scheduler must never pop a queue it saw as empty
    a_no_pop_empty: assert property (
        @(posedge dequeue_req) disable iff (!rst_n)
        deq_cmd_valid |-> (count[deq_cmd_qid] != '0)
    );

    // Source waits on enq_ready before it strobes
    a_no_enq_full: assert property (
        @(posedge dequeue_req) disable iff (!rst_n)
        enq_valid |-> enq_ready
    );

endmodule

`default_nettype wire

// File: deq_notify_if.sv
// One notification per dequeued word, no handshake
// Consumers must always accept it
`default_nettype none

interface deq_notify_if
    import router_pkg::*;
();

    logic  valid;
    qid_t  qid;
    word_t word;

    // Driven by the dequeue pipeline
    modport src (
        output valid,
        output qid,
        output word
    );

    // Scheduler and egress buffers only watch
    modport mon (
        input valid,
        input qid,
        input word
    );

endinterface

`default_nettype wire

// File: router_pkg.sv
// Port and queue counts and all depths must be powers of two
// DQ_LATENCY must be at least 1
`default_nettype none

package router_pkg;

    //////////////////////////////
    // Sizes

    localparam int NUM_EGR_PORTS = 4;
    localparam int NUM_QUEUES_PER_EGR_PORT = 4;
    localparam int NUM_QUEUES = NUM_EGR_PORTS * NUM_QUEUES_PER_EGR_PORT;
    localparam int DATA_W = 32;
    localparam int DQ_LATENCY = 2;
    localparam int QUEUE_DEPTH = 16;
    localparam int EGR_DEPTH = 8;

    // Derived widths
    localparam int PORT_W = $clog2(NUM_EGR_PORTS);
    localparam int PRIO_W = $clog2(NUM_QUEUES_PER_EGR_PORT);
    localparam int QID_W = PORT_W + PRIO_W;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int EPTR_W = $clog2(EGR_DEPTH);
    localparam int ECNT_W = $clog2(EGR_DEPTH + 1);

    // Free entries needed before a port may be granted again
    localparam int EGR_READY_FREE = DQ_LATENCY + 2;

    //////////////////////////////
    // Types

    typedef logic [PORT_W-1:0] port_t;
    typedef logic [PRIO_W-1:0] prio_t;

    typedef struct packed {
        port_t port;
        prio_t prio;
    } qid_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } word_t;

endpackage

`default_nettype wire
